//--- verilog/rv_pkg.sv
// rv32i core shared types
`default_nettype none

package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// alu operation, branch compares included
	typedef enum logic [4:0] {
		alu_add, alu_sub, alu_slt, alu_sltu,
		alu_and, alu_or, alu_xor,
		alu_sll, alu_srl, alu_sra,
		alu_lui,
		alu_beq, alu_bne, alu_blt, alu_bltu, alu_bge, alu_bgeu
	} alu_op_e;

	typedef enum logic [1:0] {
		mem_byte, mem_half, mem_word
	} mem_size_e;

	typedef enum logic [1:0] {
		jump_none, jump_jal, jump_jalr, jump_branch
	} jump_e;

	// instruction cycle of the fetch unit
	typedef enum logic [1:0] {
		ifu_fetch, ifu_exec, ifu_mem, ifu_halted
	} ifu_state_e;

	// decoded instruction
	typedef struct packed {
		alu_op_e   alu_op;
		word_t     src1;
		word_t     src2;
		reg_addr_t rd;
		logic      rd_wen;
		jump_e     jump;
		word_t     branch_target;
		logic      is_load;
		logic      is_store;
		mem_size_e mem_size;
		logic      load_unsigned;
		word_t     store_data;
		logic      ebreak;
	} dec_t;

	// wishbone classic master side
	typedef struct packed {
		word_t      adr;
		word_t      dat_w;
		logic [3:0] sel;
		logic       we;
		logic       cyc;
		logic       stb;
	} wb_req_t;

	// wishbone classic slave side
	typedef struct packed {
		word_t dat_r;
		logic  ack;
	} wb_rsp_t;

endpackage

`default_nettype wire

//--- verilog/rv_regfile.sv
// integer register file
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
	input  wire               clk,
	input  wire               arst_n,
	input  rv_pkg::reg_addr_t raddr1,
	input  rv_pkg::reg_addr_t raddr2,
	output rv_pkg::word_t     rdata1,
	output rv_pkg::word_t     rdata2,
	input  rv_pkg::reg_addr_t waddr,
	input  rv_pkg::word_t     wdata,
	input  wire               wen
);

	// x1..x31, x0 has no storage
	rv_pkg::word_t regs [1:31];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- verilog/rv_idu.sv
// rv32i instruction decoder
`timescale 1ns/1ns
`default_nettype none

module rv_idu (
	input  rv_pkg::word_t     inst,
	input  rv_pkg::word_t     pc,
	input  rv_pkg::word_t     rdata1,
	input  rv_pkg::word_t     rdata2,
	output rv_pkg::reg_addr_t raddr1,
	output rv_pkg::reg_addr_t raddr2,
	output rv_pkg::dec_t      dec
);

	localparam logic [6:0] op_imm    = 7'b001_0011;
	localparam logic [6:0] op_reg    = 7'b011_0011;
	localparam logic [6:0] op_lui    = 7'b011_0111;
	localparam logic [6:0] op_auipc  = 7'b001_0111;
	localparam logic [6:0] op_jal    = 7'b110_1111;
	localparam logic [6:0] op_jalr   = 7'b110_0111;
	localparam logic [6:0] op_branch = 7'b110_0011;
	localparam logic [6:0] op_load   = 7'b000_0011;
	localparam logic [6:0] op_store  = 7'b010_0011;
	localparam logic [6:0] op_system = 7'b111_0011;

	logic [6:0]    opcode;
	logic [2:0]    funct3;
	logic [6:0]    funct7;
	rv_pkg::word_t imm_i;
	rv_pkg::word_t imm_s;
	rv_pkg::word_t imm_b;
	rv_pkg::word_t imm_u;
	rv_pkg::word_t imm_j;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign raddr1 = inst[19:15];
	assign raddr2 = inst[24:20];

	// immediates sign extended from bit 31
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		// defaults describe a no-op on register operands
		dec.alu_op        = rv_pkg::alu_add;
		dec.src1          = rdata1;
		dec.src2          = rdata2;
		dec.rd            = inst[11:7];
		dec.rd_wen        = 1'b0;
		dec.jump          = rv_pkg::jump_none;
		dec.branch_target = pc + imm_b;
		dec.is_load       = 1'b0;
		dec.is_store      = 1'b0;
		dec.mem_size      = rv_pkg::mem_word;
		dec.load_unsigned = 1'b0;
		dec.store_data    = rdata2;
		dec.ebreak        = 1'b0;

		unique case (opcode)
			op_imm: begin
				dec.src2   = imm_i;
				dec.rd_wen = 1'b1;
				unique case (funct3)
					3'b000: dec.alu_op = rv_pkg::alu_add;
					3'b010: dec.alu_op = rv_pkg::alu_slt;
					3'b011: dec.alu_op = rv_pkg::alu_sltu;
					3'b100: dec.alu_op = rv_pkg::alu_xor;
					3'b110: dec.alu_op = rv_pkg::alu_or;
					3'b111: dec.alu_op = rv_pkg::alu_and;
					3'b001: begin
						dec.alu_op = rv_pkg::alu_sll;
						dec.rd_wen = (funct7 == 7'b000_0000);
					end
					default: begin
						// srli and srai differ in bit 30 only
						dec.alu_op = inst[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
						dec.rd_wen = (funct7 == 7'b000_0000) || (funct7 == 7'b010_0000);
					end
				endcase
			end
			op_reg: begin
				if (funct7 == 7'b000_0000) begin
					dec.rd_wen = 1'b1;
					unique case (funct3)
						3'b000: dec.alu_op = rv_pkg::alu_add;
						3'b001: dec.alu_op = rv_pkg::alu_sll;
						3'b010: dec.alu_op = rv_pkg::alu_slt;
						3'b011: dec.alu_op = rv_pkg::alu_sltu;
						3'b100: dec.alu_op = rv_pkg::alu_xor;
						3'b101: dec.alu_op = rv_pkg::alu_srl;
						3'b110: dec.alu_op = rv_pkg::alu_or;
						default: dec.alu_op = rv_pkg::alu_and;
					endcase
				end else if (funct7 == 7'b010_0000) begin
					dec.rd_wen = (funct3 == 3'b000) || (funct3 == 3'b101);
					dec.alu_op = (funct3 == 3'b000) ? rv_pkg::alu_sub : rv_pkg::alu_sra;
				end
			end
			op_lui: begin
				dec.src1   = '0;
				dec.src2   = imm_u;
				dec.alu_op = rv_pkg::alu_lui;
				dec.rd_wen = 1'b1;
			end
			op_auipc: begin
				dec.src1   = pc;
				dec.src2   = imm_u;
				dec.rd_wen = 1'b1;
			end
			op_jal: begin
				dec.src1   = pc;
				dec.src2   = imm_j;
				dec.jump   = rv_pkg::jump_jal;
				dec.rd_wen = 1'b1;
			end
			op_jalr: begin
				dec.src2 = imm_i;
				if (funct3 == 3'b000) begin
					dec.jump   = rv_pkg::jump_jalr;
					dec.rd_wen = 1'b1;
				end
			end
			op_branch: begin
				// both operands stay on the register ports
				dec.jump = rv_pkg::jump_branch;
				unique case (funct3)
					3'b000: dec.alu_op = rv_pkg::alu_beq;
					3'b001: dec.alu_op = rv_pkg::alu_bne;
					3'b100: dec.alu_op = rv_pkg::alu_blt;
					3'b101: dec.alu_op = rv_pkg::alu_bge;
					3'b110: dec.alu_op = rv_pkg::alu_bltu;
					3'b111: dec.alu_op = rv_pkg::alu_bgeu;
					default: dec.jump = rv_pkg::jump_none;
				endcase
			end
			op_load: begin
				dec.src2          = imm_i;
				dec.mem_size      = rv_pkg::mem_size_e'({1'b0, funct3[1:0]});
				dec.load_unsigned = funct3[2];
				dec.is_load       = (funct3[1:0] != 2'b11) && (funct3 != 3'b110);
				dec.rd_wen        = dec.is_load;
			end
			op_store: begin
				dec.src2     = imm_s;
				dec.mem_size = rv_pkg::mem_size_e'({1'b0, funct3[1:0]});
				dec.is_store = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
			end
			op_system: begin
				dec.ebreak = (inst == 32'h0010_0073);
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/rv_exu.sv
// alu and next pc selection
`timescale 1ns/1ns
`default_nettype none

module rv_exu (
	input  rv_pkg::dec_t  dec,
	input  rv_pkg::word_t pc,
	input  rv_pkg::word_t load_data,
	output rv_pkg::word_t next_pc,
	output rv_pkg::word_t wb_data,
	output rv_pkg::word_t mem_addr
);

	rv_pkg::word_t sum;
	rv_pkg::word_t alu_result;
	rv_pkg::word_t pc_plus4;
	logic [4:0]    shamt;
	logic          taken;

	assign sum      = dec.src1 + dec.src2;
	assign pc_plus4 = pc + 32'd4;
	assign shamt    = dec.src2[4:0];
	assign mem_addr = sum;

	always_comb begin
		unique case (dec.alu_op)
			rv_pkg::alu_add:  alu_result = sum;
			rv_pkg::alu_sub:  alu_result = dec.src1 - dec.src2;
			rv_pkg::alu_slt:  alu_result = {31'b0, $signed(dec.src1) < $signed(dec.src2)};
			rv_pkg::alu_sltu: alu_result = {31'b0, dec.src1 < dec.src2};
			rv_pkg::alu_and:  alu_result = dec.src1 & dec.src2;
			rv_pkg::alu_or:   alu_result = dec.src1 | dec.src2;
			rv_pkg::alu_xor:  alu_result = dec.src1 ^ dec.src2;
			rv_pkg::alu_sll:  alu_result = dec.src1 << shamt;
			rv_pkg::alu_srl:  alu_result = dec.src1 >> shamt;
			rv_pkg::alu_sra:  alu_result = rv_pkg::word_t'($signed(dec.src1) >>> shamt);
			rv_pkg::alu_lui:  alu_result = dec.src2;
			// compare results land in bit 0
			rv_pkg::alu_beq:  alu_result = {31'b0, dec.src1 == dec.src2};
			rv_pkg::alu_bne:  alu_result = {31'b0, dec.src1 != dec.src2};
			rv_pkg::alu_blt:  alu_result = {31'b0, $signed(dec.src1) < $signed(dec.src2)};
			rv_pkg::alu_bltu: alu_result = {31'b0, dec.src1 < dec.src2};
			rv_pkg::alu_bge:  alu_result = {31'b0, $signed(dec.src1) >= $signed(dec.src2)};
			rv_pkg::alu_bgeu: alu_result = {31'b0, dec.src1 >= dec.src2};
			default:          alu_result = '0;
		endcase
	end

	assign taken = (dec.jump == rv_pkg::jump_branch) && alu_result[0];

	always_comb begin
		unique case (dec.jump)
			rv_pkg::jump_branch: next_pc = taken ? dec.branch_target : pc_plus4;
			rv_pkg::jump_jalr:   next_pc = {alu_result[31:1], 1'b0};
			// jal adds the j immediate to the pc in the alu
			rv_pkg::jump_jal:    next_pc = alu_result;
			default:             next_pc = pc_plus4;
		endcase
	end

	always_comb begin
		if (dec.jump == rv_pkg::jump_jal || dec.jump == rv_pkg::jump_jalr) begin
			wb_data = pc_plus4;
		end else if (dec.is_load) begin
			wb_data = load_data;
		end else begin
			wb_data = alu_result;
		end
	end

endmodule

`default_nettype wire

//--- verilog/rv_lsu.sv
// wishbone load store unit
`timescale 1ns/1ns
`default_nettype none

module rv_lsu (
	input  wire               clk,
	input  wire               arst_n,
	input  wire               start,
	input  rv_pkg::dec_t      dec,
	input  rv_pkg::word_t     addr,
	output rv_pkg::wb_req_t   dmem_req,
	input  rv_pkg::wb_rsp_t   dmem_rsp,
	output rv_pkg::word_t     load_data,
	output logic              done
);

	rv_pkg::wb_req_t   req;
	rv_pkg::mem_size_e size_q;
	logic              unsigned_q;
	logic [1:0]        lane_q;
	logic [3:0]        sel;
	rv_pkg::word_t     wdata;
	rv_pkg::word_t     shifted;

	// byte lanes from size and low address bits
	always_comb begin
		unique case (dec.mem_size)
			rv_pkg::mem_byte: begin
				sel   = 4'b0001 << addr[1:0];
				wdata = {4{dec.store_data[7:0]}};
			end
			rv_pkg::mem_half: begin
				sel   = addr[1] ? 4'b1100 : 4'b0011;
				wdata = {2{dec.store_data[15:0]}};
			end
			default: begin
				sel   = 4'b1111;
				wdata = dec.store_data;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req        <= '0;
			size_q     <= rv_pkg::mem_word;
			unsigned_q <= 1'b0;
			lane_q     <= '0;
		end else if (start) begin
			req.adr    <= {addr[31:2], 2'b00};
			req.dat_w  <= wdata;
			req.sel    <= sel;
			req.we     <= dec.is_store;
			req.cyc    <= 1'b1;
			req.stb    <= 1'b1;
			size_q     <= dec.mem_size;
			unsigned_q <= dec.load_unsigned;
			lane_q     <= addr[1:0];
		end else if (req.cyc && dmem_rsp.ack) begin
			req.cyc <= 1'b0;
			req.stb <= 1'b0;
		end
	end

	assign dmem_req = req;
	// done in the ack cycle so the load retires on the ack edge
	assign done     = req.cyc && dmem_rsp.ack;

	// selected lane moved down to bit 0
	assign shifted = dmem_rsp.dat_r >> {lane_q, 3'b000};

	always_comb begin
		unique case (size_q)
			rv_pkg::mem_byte: load_data = {{24{!unsigned_q && shifted[7]}}, shifted[7:0]};
			rv_pkg::mem_half: load_data = {{16{!unsigned_q && shifted[15]}}, shifted[15:0]};
			default:          load_data = dmem_rsp.dat_r;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/rv_ifu.sv
// fetch unit and instruction cycle
`timescale 1ns/1ns
`default_nettype none

module rv_ifu #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input  wire             clk,
	input  wire             arst_n,
	output rv_pkg::wb_req_t imem_req,
	input  rv_pkg::wb_rsp_t imem_rsp,
	input  rv_pkg::dec_t    dec,
	input  rv_pkg::word_t   next_pc,
	input  wire             lsu_done,
	output rv_pkg::word_t   inst,
	output rv_pkg::word_t   pc,
	output logic            lsu_start,
	output logic            rf_wen,
	output logic            halt
);

	rv_pkg::ifu_state_e state;
	rv_pkg::wb_req_t    ireq;
	logic               is_mem;
	logic               retire;

	assign is_mem = dec.is_load || dec.is_store;

	// non memory ops retire out of exec, memory ops on the data ack
	assign retire = (state == rv_pkg::ifu_exec && !is_mem && !dec.ebreak)
			|| (state == rv_pkg::ifu_mem && lsu_done);

	assign rf_wen    = retire && dec.rd_wen;
	assign lsu_start = (state == rv_pkg::ifu_exec) && is_mem;
	assign halt      = (state == rv_pkg::ifu_halted);
	assign imem_req  = ireq;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= rv_pkg::ifu_fetch;
			pc    <= reset_pc;
			inst  <= '0;
			ireq  <= '0;
		end else begin
			unique case (state)
				rv_pkg::ifu_fetch: begin
					if (!ireq.cyc) begin
						// first fetch after reset
						ireq.adr <= pc;
						ireq.sel <= 4'b1111;
						ireq.cyc <= 1'b1;
						ireq.stb <= 1'b1;
					end else if (imem_rsp.ack) begin
						inst     <= imem_rsp.dat_r;
						ireq.cyc <= 1'b0;
						ireq.stb <= 1'b0;
						state    <= rv_pkg::ifu_exec;
					end
				end
				rv_pkg::ifu_exec: begin
					if (dec.ebreak) begin
						state <= rv_pkg::ifu_halted;
					end else if (is_mem) begin
						state <= rv_pkg::ifu_mem;
					end
				end
				default: begin
				end
			endcase

			// retire starts the next fetch right away
			if (retire) begin
				pc       <= next_pc;
				ireq.adr <= next_pc;
				ireq.sel <= 4'b1111;
				ireq.cyc <= 1'b1;
				ireq.stb <= 1'b1;
				state    <= rv_pkg::ifu_fetch;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
// rv32i multi-cycle core
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input  wire             clk,
	input  wire             arst_n,
	output rv_pkg::wb_req_t imem_req,
	input  rv_pkg::wb_rsp_t imem_rsp,
	output rv_pkg::wb_req_t dmem_req,
	input  rv_pkg::wb_rsp_t dmem_rsp,
	output wire             halt
);

	rv_pkg::word_t     inst;
	rv_pkg::word_t     pc;
	rv_pkg::word_t     rdata1;
	rv_pkg::word_t     rdata2;
	rv_pkg::reg_addr_t raddr1;
	rv_pkg::reg_addr_t raddr2;
	rv_pkg::dec_t      dec;
	rv_pkg::word_t     next_pc;
	rv_pkg::word_t     wb_data;
	rv_pkg::word_t     mem_addr;
	rv_pkg::word_t     load_data;
	wire               lsu_start;
	wire               lsu_done;
	wire               rf_wen;

	rv_ifu #(.reset_pc(reset_pc)) i_ifu (
		.clk(clk), .arst_n(arst_n), .imem_req(imem_req), .imem_rsp(imem_rsp),
		.dec(dec), .next_pc(next_pc), .lsu_done(lsu_done), .inst(inst), .pc(pc),
		.lsu_start(lsu_start), .rf_wen(rf_wen), .halt(halt)
	);

	rv_idu i_idu (
		.inst(inst), .pc(pc), .rdata1(rdata1), .rdata2(rdata2),
		.raddr1(raddr1), .raddr2(raddr2), .dec(dec)
	);

	rv_regfile i_regfile (
		.clk(clk), .arst_n(arst_n), .raddr1(raddr1), .raddr2(raddr2),
		.rdata1(rdata1), .rdata2(rdata2), .waddr(dec.rd), .wdata(wb_data), .wen(rf_wen)
	);

	rv_exu i_exu (
		.dec(dec), .pc(pc), .load_data(load_data),
		.next_pc(next_pc), .wb_data(wb_data), .mem_addr(mem_addr)
	);

	rv_lsu i_lsu (
		.clk(clk), .arst_n(arst_n), .start(lsu_start), .dec(dec), .addr(mem_addr),
		.dmem_req(dmem_req), .dmem_rsp(dmem_rsp), .load_data(load_data), .done(lsu_done)
	);

endmodule

`default_nettype wire

//--- bench/tb_wb_mem.sv
// dual port wishbone memory model
`timescale 1ns/1ns
`default_nettype none

module tb_wb_mem #(
	parameter int unsigned seed = 32221
) (
	input  wire             clk,
	input  wire             arst_n,
	input  rv_pkg::wb_req_t imem_req,
	output rv_pkg::wb_rsp_t imem_rsp,
	input  rv_pkg::wb_req_t dmem_req,
	output rv_pkg::wb_rsp_t dmem_rsp
);

	rv_pkg::word_t   imem [0:63];
	rv_pkg::word_t   dmem [0:63];
	// every completed data write, in bus order
	rv_pkg::wb_req_t wr_log [$];
	logic [31:0]     lcg_state = seed;
	int              iwait = 0;
	int              dwait = 0;

	// wait states of 0 to 3 cycles
	function automatic int next_wait();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[17:16]);
	endfunction

	initial begin
		imem_rsp = '0;
		dmem_rsp = '0;
	end

	always @(posedge clk) begin
		#5;
		if (!arst_n) begin
			imem_rsp = '0;
		end else begin
			imem_rsp.ack = 1'b0;
			if (imem_req.cyc && imem_req.stb) begin
				if (iwait == 0) begin
					imem_rsp.dat_r = imem[imem_req.adr[7:2]];
					imem_rsp.ack   = 1'b1;
					iwait          = next_wait();
				end else begin
					iwait--;
				end
			end
		end
	end

	always @(posedge clk) begin
		#5;
		if (!arst_n) begin
			dmem_rsp = '0;
		end else begin
			dmem_rsp.ack = 1'b0;
			if (dmem_req.cyc && dmem_req.stb) begin
				if (dwait == 0) begin
					if (dmem_req.we) begin
						for (int b = 0; b < 4; b++) begin
							if (dmem_req.sel[b]) begin
								dmem[dmem_req.adr[7:2]][8*b +: 8] = dmem_req.dat_w[8*b +: 8];
							end
						end
						wr_log.push_back(dmem_req);
					end
					dmem_rsp.dat_r = dmem[dmem_req.adr[7:2]];
					dmem_rsp.ack   = 1'b1;
					dwait          = next_wait();
				end else begin
					dwait--;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/tb_rv_core.sv
// rv32i core testbench
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

	localparam int            max_wait     = 3;
	localparam int            reset_cycles = 10;
	localparam int            quiet_cycles = 20;
	localparam rv_pkg::word_t ebreak_inst  = 32'h0010_0073;
	localparam rv_pkg::word_t preload_end  = 32'hffff_ffff;

	typedef struct packed {
		rv_pkg::word_t adr;
		rv_pkg::word_t dat;
	} preload_t;

	// sel of zero closes a row
	typedef struct packed {
		rv_pkg::word_t adr;
		logic [3:0]    sel;
		rv_pkg::word_t dat;
	} store_rec_t;

	logic            clk;
	logic            arst_n;
	rv_pkg::wb_req_t imem_req;
	rv_pkg::wb_rsp_t imem_rsp;
	rv_pkg::wb_req_t dmem_req;
	rv_pkg::wb_rsp_t dmem_rsp;
	wire             halt;
	int unsigned     cycles = 0;
	int unsigned     limit = 32'hffff_ffff;

	// programs back to back with each row closed by ebreak
	rv_pkg::word_t prog_q [$] = '{
		// row 0 alu ops
		32'hff900093, 32'h00300113, 32'h002081b3, 32'h04302023, 32'h40110233,
		32'h04402223, 32'h4010d293, 32'h04502423, 32'h0010d313, 32'h04602623,
		32'h0020a3b3, 32'h0020b433, 32'h04702823, 32'h04802a23, 32'h0ff0f493,
		32'h0020e533, 32'h0020c5b3, 32'h00211633, 32'h04902c23, 32'h04a02e23,
		32'h06b02023, 32'h06c02223, 32'h00100073,
		// row 1 lui, auipc, x0
		32'h123450b7, 32'h00001117, 32'h00500013, 32'h04102023, 32'h04202223,
		32'h04002423, 32'hfffff1b7, 32'h04302623, 32'h00100073,
		// row 2 branch pairs
		32'hfff00093, 32'h00100113, 32'h05500193,
		32'h00208463, 32'h04302023, 32'h00209463, 32'h04302223,
		32'h0020c463, 32'h04302423, 32'h0020d463, 32'h04302623,
		32'h0020e463, 32'h04302823, 32'h0020f463, 32'h04302a23,
		32'h00210463, 32'h04302c23, 32'h00211463, 32'h04302e23,
		32'h00114463, 32'h06302023, 32'h00115463, 32'h06302223,
		32'h00116463, 32'h06302423, 32'h00117463, 32'h06302623, 32'h00100073,
		// row 3 jal and jalr with auipc at the jalr target
		32'h008000ef, 32'h04102023, 32'h04102223, 32'h01900293, 32'h00028367,
		32'h04602423, 32'h00000397, 32'h04602623, 32'h04702823, 32'h00100073,
		// row 4 sub-word stores and loads
		32'h6a500093, 32'h041000a3, 32'h04101323, 32'h041005a3,
		32'h08000103, 32'h08304183, 32'h08201203, 32'h08005283, 32'h08002303,
		32'h08100383, 32'h04202823, 32'h04302a23, 32'h04402c23, 32'h04502e23,
		32'h06602023, 32'h06702223, 32'h00100073
	};

	preload_t preload_q [$] = '{
		{preload_end, 32'h0}, {preload_end, 32'h0}, {preload_end, 32'h0},
		{preload_end, 32'h0},
		{32'h80, 32'h80f1_7f82}, {preload_end, 32'h0}
	};

	store_rec_t expect_q [$] = '{
		{32'h40, 4'hf, 32'hffff_fffc}, {32'h44, 4'hf, 32'h0000_000a},
		{32'h48, 4'hf, 32'hffff_fffc}, {32'h4c, 4'hf, 32'h7fff_fffc},
		{32'h50, 4'hf, 32'h0000_0001}, {32'h54, 4'hf, 32'h0000_0000},
		{32'h58, 4'hf, 32'h0000_00f9}, {32'h5c, 4'hf, 32'hffff_fffb},
		{32'h60, 4'hf, 32'hffff_fffa}, {32'h64, 4'hf, 32'h0000_0018}, {32'h0, 4'h0, 32'h0},
		{32'h40, 4'hf, 32'h1234_5000}, {32'h44, 4'hf, 32'h0000_1004},
		{32'h48, 4'hf, 32'h0000_0000}, {32'h4c, 4'hf, 32'hffff_f000}, {32'h0, 4'h0, 32'h0},
		{32'h40, 4'hf, 32'h55}, {32'h4c, 4'hf, 32'h55}, {32'h50, 4'hf, 32'h55},
		{32'h5c, 4'hf, 32'h55}, {32'h60, 4'hf, 32'h55}, {32'h6c, 4'hf, 32'h55},
		{32'h0, 4'h0, 32'h0},
		{32'h44, 4'hf, 32'h0000_0004}, {32'h4c, 4'hf, 32'h0000_0014},
		{32'h50, 4'hf, 32'h0000_0018}, {32'h0, 4'h0, 32'h0},
		{32'h40, 4'h2, 32'ha5a5_a5a5}, {32'h44, 4'hc, 32'h06a5_06a5},
		{32'h48, 4'h8, 32'ha5a5_a5a5}, {32'h50, 4'hf, 32'hffff_ff82},
		{32'h54, 4'hf, 32'h0000_0080}, {32'h58, 4'hf, 32'hffff_80f1},
		{32'h5c, 4'hf, 32'h0000_7f82}, {32'h60, 4'hf, 32'h80f1_7f82},
		{32'h64, 4'hf, 32'h0000_007f}, {32'h0, 4'h0, 32'h0}
	};

	rv_core #(.reset_pc(32'h0)) i_dut (
		.clk(clk), .arst_n(arst_n), .imem_req(imem_req), .imem_rsp(imem_rsp),
		.dmem_req(dmem_req), .dmem_rsp(dmem_rsp), .halt(halt)
	);

	tb_wb_mem #(.seed(32221)) i_mem (
		.clk(clk), .arst_n(arst_n), .imem_req(imem_req), .imem_rsp(imem_rsp),
		.dmem_req(dmem_req), .dmem_rsp(dmem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("TEST RESULT: FAIL");
			$fatal(1, "run did not reach halt within %0d cycles, core state %s",
				limit, i_dut.i_ifu.state.name());
		end
	end

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// background data that differs for every word
	function automatic rv_pkg::word_t fill_word(input int idx);
		return 32'hd00d_0000 | (idx * 4);
	endfunction

	initial begin
		int pi;
		int di;
		int ei;
		int wi;
		int rows;
		int n_exp;

		arst_n = 1'b0;
		pi     = 0;
		di     = 0;
		ei     = 0;
		rows   = 0;
		foreach (prog_q[k]) begin
			if (prog_q[k] == ebreak_inst) begin
				rows++;
			end
		end
		limit = prog_q.size() * (2 + 2 * max_wait) + prog_q.size() * 2
			+ rows * (reset_cycles + quiet_cycles + 4);

		for (int row = 0; row < rows; row++) begin
			@(posedge clk);
			#5;
			arst_n = 1'b0;
			for (int a = 0; a < 64; a++) begin
				i_mem.imem[a] = ebreak_inst;
				i_mem.dmem[a] = fill_word(a);
			end
			wi = 0;
			do begin
				i_mem.imem[wi] = prog_q[pi];
				wi++;
				pi++;
			end while (prog_q[pi-1] != ebreak_inst);
			while (preload_q[di].adr != preload_end) begin
				i_mem.dmem[preload_q[di].adr[7:2]] = preload_q[di].dat;
				di++;
			end
			di++;
			i_mem.wr_log.delete();
			repeat (reset_cycles) @(posedge clk);
			#5;
			arst_n = 1'b1;

			do begin
				@(posedge clk);
				#5;
			end while (!halt);

			// halted core stays off both buses
			repeat (quiet_cycles) begin
				@(posedge clk);
				#5;
				check("halt", 32'd1, halt);
				check("imem_req.cyc", 32'd0, imem_req.cyc);
				check("dmem_req.cyc", 32'd0, dmem_req.cyc);
			end

			n_exp = 0;
			while (expect_q[ei + n_exp].sel != 4'h0) begin
				n_exp++;
			end
			check("store count", n_exp, i_mem.wr_log.size());
			for (int k = 0; k < n_exp; k++) begin
				check("dmem_req.adr", expect_q[ei + k].adr, i_mem.wr_log[k].adr);
				check("dmem_req.sel", expect_q[ei + k].sel, i_mem.wr_log[k].sel);
				check("dmem_req.dat_w", expect_q[ei + k].dat, i_mem.wr_log[k].dat_w);
			end
			ei = ei + n_exp + 1;
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
verilog/rv_pkg.sv
verilog/rv_regfile.sv
verilog/rv_idu.sv
verilog/rv_exu.sv
verilog/rv_lsu.sv
verilog/rv_ifu.sv
verilog/rv_core.sv
bench/tb_wb_mem.sv
bench/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_pkg.sv
  - verilog/rv_regfile.sv
  - verilog/rv_idu.sv
  - verilog/rv_exu.sv
  - verilog/rv_lsu.sv
  - verilog/rv_ifu.sv
  - verilog/rv_core.sv
  - target: simulation
    files:
      - bench/tb_wb_mem.sv
      - bench/tb_rv_core.sv
